// ==== hdl/uart_rx_pkg.sv ====
`default_nettype none

package uart_rx_pkg;

    // ==================================================
    // Character format
    // ==================================================

    localparam int DATA_WIDTH = 8;                 // Data bits per character

    typedef logic [DATA_WIDTH-1:0] rx_data_t;       // One received character
    typedef logic [3:0]            bit_index_t;     // Counts data bits

    // ==================================================
    // Status and frame structs
    // ==================================================

    // Status shown next to the held character
    typedef struct packed {
        logic frame_error;                          // Stop bit read as 0
        logic overrun;                              // Unread character overwritten
    } rx_status_t;

    // Completed character handed from datapath to buffer
    typedef struct packed {
        rx_data_t data;
        logic     frame_error;
    } rx_frame_t;

    // ==================================================
    // Receiver FSM states
    // ==================================================

    typedef enum logic [2:0] {
        IDLE,                                       // Line idle, wait for falling edge
        VALIDATE_START,                             // Re-check start bit at its middle
        READ_DATA,                                  // Sample DATA_WIDTH data bits
        STOP,                                       // Sample the stop bit
        DATA_READY                                  // Hand the frame to the buffer
    } rx_state_t;

endpackage

`default_nettype wire

// ==== hdl/rx_sample_timer.sv ====
`default_nettype none

module rx_sample_timer #(
    parameter int CLOCK_SPEED       = 20_000_000,
    parameter int BAUD_RATE         = 9600,
    parameter int OVERSAMPLING_RATE = 16
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  i_enable,
    input  wire  i_restart,
    output logic o_mid_bit,
    output logic o_end_bit
);

    // ==================================================
    // Derived counts
    // ==================================================

    localparam int CYCLES_PER_SAMPLE = CLOCK_SPEED / (BAUD_RATE * OVERSAMPLING_RATE);
    localparam int CYCLE_W  = (CYCLES_PER_SAMPLE > 1) ? $clog2(CYCLES_PER_SAMPLE) : 1;
    localparam int SAMPLE_W = (OVERSAMPLING_RATE > 1) ? $clog2(OVERSAMPLING_RATE) : 1;

    localparam logic [CYCLE_W-1:0]  LAST_CYCLE  = CYCLE_W'(CYCLES_PER_SAMPLE - 1);
    localparam logic [SAMPLE_W-1:0] MID_SAMPLE  = SAMPLE_W'(OVERSAMPLING_RATE / 2 - 1);
    localparam logic [SAMPLE_W-1:0] LAST_SAMPLE = SAMPLE_W'(OVERSAMPLING_RATE - 1);

    logic [CYCLE_W-1:0]  cycle_count;               // Clock cycles within one sample
    logic [SAMPLE_W-1:0] sample_count;              // Samples within one bit
    logic                sample_tick;               // Last cycle of a sample period

    assign sample_tick = i_enable && (cycle_count == LAST_CYCLE);

    // ==================================================
    // Counters and event pulses
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count  <= '0;
            sample_count <= '0;
            o_mid_bit    <= 1'b0;
            o_end_bit    <= 1'b0;
        end else if (i_restart) begin
            // New bit timing reference
            cycle_count  <= '0;
            sample_count <= '0;
            o_mid_bit    <= 1'b0;
            o_end_bit    <= 1'b0;
        end else begin
            o_mid_bit <= sample_tick && (sample_count == MID_SAMPLE);
            o_end_bit <= sample_tick && (sample_count == LAST_SAMPLE);

            if (i_enable) begin
                if (cycle_count == LAST_CYCLE) begin
                    cycle_count <= '0;
                    if (sample_count == LAST_SAMPLE) begin
                        sample_count <= '0;             // Wrap at bit end
                    end else begin
                        sample_count <= sample_count + 1'b1;
                    end
                end else begin
                    cycle_count <= cycle_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rx_control_fsm.sv ====
`default_nettype none

module rx_control_fsm (
    input  wire  clk,
    input  wire  reset,
    input  wire  i_rx_bit,
    input  wire  i_mid_bit,
    input  wire  i_end_bit,
    output logic o_timer_enable,
    output logic o_timer_restart,
    output logic o_shift_en,
    output logic o_stop_sample,
    output logic o_frame_done
);

    import uart_rx_pkg::*;

    localparam logic       START_LEVEL   = 1'b0;
    localparam bit_index_t LAST_DATA_BIT = bit_index_t'(DATA_WIDTH - 1);

    rx_state_t  state;
    rx_state_t  next_state;
    bit_index_t bit_count;                          // Data bits taken so far
    bit_index_t next_bit_count;

    // ==================================================
    // Next state and commands
    // ==================================================

    always_comb begin
        next_state      = state;
        next_bit_count  = bit_count;
        o_timer_enable  = 1'b0;
        o_timer_restart = 1'b0;
        o_shift_en      = 1'b0;
        o_stop_sample   = 1'b0;
        o_frame_done    = 1'b0;

        case (state)
            IDLE: begin
                if (i_rx_bit == START_LEVEL) begin
                    next_state      = VALIDATE_START;
                    next_bit_count  = '0;
                    o_timer_restart = 1'b1;     // Time from the falling edge
                end
            end

            VALIDATE_START: begin
                o_timer_enable = 1'b1;
                if (i_mid_bit) begin
                    if (i_rx_bit == START_LEVEL) begin
                        next_state      = READ_DATA;
                        o_timer_restart = 1'b1; // Re-align to start bit center
                    end else begin
                        next_state = IDLE;      // Glitch, not a start bit
                    end
                end
            end

            READ_DATA: begin
                o_timer_enable = 1'b1;
                if (i_end_bit) begin
                    o_shift_en = 1'b1;
                    if (bit_count == LAST_DATA_BIT) begin
                        next_state     = STOP;
                        next_bit_count = '0;
                    end else begin
                        next_bit_count = bit_count + 1'b1;
                    end
                end
            end

            STOP: begin
                o_timer_enable = 1'b1;
                if (i_end_bit) begin
                    o_stop_sample = 1'b1;       // Stop bit center
                    next_state    = DATA_READY;
                end
            end

            DATA_READY: begin
                o_frame_done = 1'b1;
                next_state   = IDLE;
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // ==================================================
    // State registers
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            bit_count <= '0;
        end else begin
            state     <= next_state;
            bit_count <= next_bit_count;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rx_shift_datapath.sv ====
`default_nettype none

module rx_shift_datapath (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   i_rx_serial,
    input  wire                   i_shift_en,
    input  wire                   i_stop_sample,
    input  wire                   i_frame_done,
    output logic                  o_rx_bit,
    output uart_rx_pkg::rx_frame_t o_frame,
    output logic                  o_frame_strobe
);

    import uart_rx_pkg::*;

    // ==================================================
    // Input synchronizer
    // ==================================================

    logic sync_ff1;                                 // First stage, may go metastable

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_ff1 <= 1'b1;                       // Idle line level
            o_rx_bit <= 1'b1;
        end else begin
            sync_ff1 <= i_rx_serial;
            o_rx_bit <= sync_ff1;
        end
    end

    // ==================================================
    // Shift register and stop bit capture
    // ==================================================

    rx_data_t shift_reg;                            // Fills from the MSB end
    logic     stop_error;                           // Stop bit sampled low

    always_ff @(posedge clk) begin
        if (i_shift_en) begin
            shift_reg <= {o_rx_bit, shift_reg[DATA_WIDTH-1:1]};
        end
        if (i_stop_sample) begin
            stop_error <= ~o_rx_bit;
        end
    end

    // ==================================================
    // Frame assembly
    // ==================================================

    always_ff @(posedge clk) begin
        if (i_frame_done) begin
            o_frame.data        <= shift_reg;
            o_frame.frame_error <= stop_error;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_frame_strobe <= 1'b0;
        end else begin
            o_frame_strobe <= i_frame_done;         // Aligned with o_frame
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rx_holding_buffer.sv ====
`default_nettype none

module rx_holding_buffer (
    input  wire                    clk,
    input  wire                    reset,
    input  uart_rx_pkg::rx_frame_t  i_frame,
    input  wire                    i_frame_strobe,
    input  wire                    i_read,
    output uart_rx_pkg::rx_data_t   o_data,
    output uart_rx_pkg::rx_status_t o_status,
    output logic                   o_valid
);

    // ==================================================
    // Held character and status
    // ==================================================

    logic overrun_next;                             // Old character still unread

    // A read in the same cycle consumes the old character first
    assign overrun_next = o_valid && !i_read;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_data   <= '0;
            o_status <= '0;
            o_valid  <= 1'b0;
        end else begin
            if (i_frame_strobe) begin
                o_data               <= i_frame.data;      // New character wins
                o_status.frame_error <= i_frame.frame_error;
                o_status.overrun     <= overrun_next;
                o_valid              <= 1'b1;
            end else if (i_read) begin
                o_status.overrun <= 1'b0;
                o_valid          <= 1'b0;                  // Frame error kept until next load
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_rx_top.sv ====
`default_nettype none

module uart_rx_top #(
    parameter int CLOCK_SPEED       = 20_000_000,
    parameter int BAUD_RATE         = 9600,
    parameter int OVERSAMPLING_RATE = 16
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    i_rx_serial,
    input  wire                    i_read,
    output uart_rx_pkg::rx_data_t   o_data,
    output uart_rx_pkg::rx_status_t o_status,
    output logic                   o_valid
);

    import uart_rx_pkg::*;

    // ==================================================
    // Internal connections
    // ==================================================

    logic      rx_bit;                              // Synchronized serial line
    logic      mid_bit;
    logic      end_bit;
    logic      timer_enable;
    logic      timer_restart;
    logic      shift_en;
    logic      stop_sample;
    logic      frame_done;
    rx_frame_t frame;
    logic      frame_strobe;

    // ==================================================
    // Blocks
    // ==================================================

    rx_sample_timer #(
        .CLOCK_SPEED      (CLOCK_SPEED),
        .BAUD_RATE        (BAUD_RATE),
        .OVERSAMPLING_RATE(OVERSAMPLING_RATE)
    ) i_rx_sample_timer (
        .clk      (clk),
        .reset    (reset),
        .i_enable (timer_enable),
        .i_restart(timer_restart),
        .o_mid_bit(mid_bit),
        .o_end_bit(end_bit)
    );

    rx_control_fsm i_rx_control_fsm (
        .clk            (clk),
        .reset          (reset),
        .i_rx_bit       (rx_bit),
        .i_mid_bit      (mid_bit),
        .i_end_bit      (end_bit),
        .o_timer_enable (timer_enable),
        .o_timer_restart(timer_restart),
        .o_shift_en     (shift_en),
        .o_stop_sample  (stop_sample),
        .o_frame_done   (frame_done)
    );

    rx_shift_datapath i_rx_shift_datapath (
        .clk           (clk),
        .reset         (reset),
        .i_rx_serial   (i_rx_serial),
        .i_shift_en    (shift_en),
        .i_stop_sample (stop_sample),
        .i_frame_done  (frame_done),
        .o_rx_bit      (rx_bit),
        .o_frame       (frame),
        .o_frame_strobe(frame_strobe)
    );

    rx_holding_buffer i_rx_holding_buffer (
        .clk           (clk),
        .reset         (reset),
        .i_frame       (frame),
        .i_frame_strobe(frame_strobe),
        .i_read        (i_read),
        .o_data        (o_data),
        .o_status      (o_status),
        .o_valid       (o_valid)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_uart_rx.sv ====
`default_nettype none

module tb_uart_rx;

    timeunit 1ns;
    timeprecision 1ps;

    import uart_rx_pkg::*;

    // ==================================================
    // Test configuration
    // ==================================================

    localparam int CLOCK_SPEED       = 4_915_200;
    localparam int BAUD_RATE         = 38_400;
    localparam int OVERSAMPLING_RATE = 16;
    localparam int CLK_PERIOD        = 8;                        // ns
    localparam int BIT_CYCLES        = CLOCK_SPEED / BAUD_RATE;  // 128 cycles per bit
    localparam int BIT_NS            = BIT_CYCLES * CLK_PERIOD;
    localparam int CASE_COLS         = 7;
    localparam int RANDOM_COUNT      = 20;
    localparam int RANDOM_SEED       = 60401;
    localparam int BITS_PER_CASE     = 12;                       // Watchdog budget per character
    localparam int WATCHDOG_MARGIN   = 60;                       // Extra bit times
    localparam int VALID_TIMEOUT     = 2 * BIT_CYCLES;
    localparam int VALID_EARLIEST_NS = BIT_NS / 2;               // Stop bit sampled at its middle
    localparam int VALID_LATEST_NS   = BIT_NS / 2 + 16 * CLK_PERIOD;
    localparam string CASES_FILE     = "testbench/uart_rx_cases.txt";

    // One character of stimulus with its expected result
    typedef struct packed {
        rx_data_t   value;
        logic       stop_level;
        logic       do_read;
        logic [7:0] glitch_len;
        rx_data_t   exp_data;
        rx_status_t exp_status;
    } char_case_t;

    logic       clk;
    logic       reset;
    logic       rx_serial;
    logic       rx_read;
    rx_data_t   rx_data;
    rx_status_t rx_status;
    logic       rx_valid;

    char_case_t cases[$];
    bit         cases_loaded = 1'b0;
    int         errors = 0;
    int         chars_checked = 0;
    int         seed;
    int         rise_count = 0;                  // o_valid rising edges seen
    time        rise_time = 0;
    time        stop_start = 0;
    logic       valid_q = 1'b0;

    uart_rx_top #(
        .CLOCK_SPEED      (CLOCK_SPEED),
        .BAUD_RATE        (BAUD_RATE),
        .OVERSAMPLING_RATE(OVERSAMPLING_RATE)
    ) i_uart_rx_top (
        .clk        (clk),
        .reset      (reset),
        .i_rx_serial(rx_serial),
        .i_read     (rx_read),
        .o_data     (rx_data),
        .o_status   (rx_status),
        .o_valid    (rx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Count rising edges of o_valid
    always @(negedge clk) begin
        if (rx_valid && !valid_q) begin
            rise_count <= rise_count + 1;
            rise_time  <= $time;
        end
        valid_q <= rx_valid;
    end

    // ==================================================
    // Stimulus tasks
    // ==================================================

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    task automatic load_cases();
        int         fd;
        int         count;
        string      line;
        int         col [CASE_COLS];
        char_case_t tc;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Cases file %s could not be opened", CASES_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    count = $sscanf(line, "%h %h %h %h %h %h %h", col[0], col[1], col[2],
                                    col[3], col[4], col[5], col[6]);
                    if (count == CASE_COLS) begin                 // Comment lines skipped
                        tc.value                  = rx_data_t'(col[0]);
                        tc.stop_level             = col[1][0];
                        tc.do_read                = col[2][0];
                        tc.glitch_len             = col[3][7:0];
                        tc.exp_data               = rx_data_t'(col[4]);
                        tc.exp_status.frame_error = col[5][0];
                        tc.exp_status.overrun     = col[6][0];
                        cases.push_back(tc);
                    end
                end
            end
            $fclose(fd);
        end
        cases_loaded = 1'b1;
    endtask

    task automatic send_char(input rx_data_t value, input logic stop_level);
        rx_serial = 1'b0;                                        // Start bit
        wait_cycles(BIT_CYCLES);
        for (int i = 0; i < DATA_WIDTH; i++) begin
            rx_serial = value[i];                                // LSB first
            wait_cycles(BIT_CYCLES);
        end
        stop_start = $time;
        rx_serial  = stop_level;
        wait_cycles(BIT_CYCLES);
        rx_serial = 1'b1;                                        // Back to idle
    endtask

    task automatic send_glitch(input int length);
        rx_serial = 1'b0;
        wait_cycles(length);
        rx_serial = 1'b1;
        wait_cycles(11 * BIT_CYCLES);                            // Longer than a whole false frame
    endtask

    // ==================================================
    // One character: send, wait, check, read
    // ==================================================

    task automatic run_case(input char_case_t tc);
        int   rises_before;
        int   waited;
        int   delay_ns;
        logic was_valid;
        if (tc.glitch_len != '0) begin
            rises_before = rise_count;
            send_glitch(int'(tc.glitch_len));
            assert (rise_count == rises_before) else begin
                $display("FAILED at %0t: glitch of %0d cycles raised o_valid",
                         $time, tc.glitch_len);
                errors++;
            end
        end

        was_valid    = rx_valid;
        rises_before = rise_count;
        send_char(tc.value, tc.stop_level);

        if (was_valid) begin
            wait_cycles(4);                                      // Old character still held
        end else begin
            waited = 0;
            while (rise_count == rises_before && waited < VALID_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
        end

        if (!was_valid && rise_count == rises_before) begin
            $display("Timeout at %0t: o_valid never rose for character %h", $time, tc.value);
            errors++;
        end else begin
            if (!was_valid) begin
                delay_ns = int'(rise_time - stop_start);
                assert (delay_ns >= VALID_EARLIEST_NS && delay_ns <= VALID_LATEST_NS) else begin
                    $display("FAILED at %0t: o_valid rose %0d ns after stop bit start",
                             $time, delay_ns);
                    errors++;
                end
            end
            assert (rx_data == tc.exp_data) else begin
                $display("FAILED at %0t: data %h, expected %h", $time, rx_data, tc.exp_data);
                errors++;
            end
            assert (rx_status == tc.exp_status) else begin
                $display("FAILED at %0t: status fe=%b ov=%b, expected fe=%b ov=%b", $time,
                         rx_status.frame_error, rx_status.overrun,
                         tc.exp_status.frame_error, tc.exp_status.overrun);
                errors++;
            end
        end
        chars_checked++;

        if (tc.do_read) begin
            rx_read = 1'b1;
            @(negedge clk);
            rx_read = 1'b0;
            @(negedge clk);
            assert (!rx_valid && !rx_status.overrun) else begin
                $display("FAILED at %0t: read left valid=%b overrun=%b",
                         $time, rx_valid, rx_status.overrun);
                errors++;
            end
        end
        wait_cycles(BIT_CYCLES);                                 // Idle gap
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        char_case_t tc;
        rx_serial = 1'b1;
        rx_read   = 1'b0;
        reset     = 1'b1;
        seed      = RANDOM_SEED;
        load_cases();

        wait_cycles(3);
        reset = 1'b0;
        @(negedge clk);
        assert (!rx_valid && rx_status == '0 && rx_data == '0) else begin
            $display("FAILED at %0t: after reset valid=%b status=%b data=%h",
                     $time, rx_valid, rx_status, rx_data);
            errors++;
        end

        foreach (cases[n]) begin
            run_case(cases[n]);
        end

        for (int n = 0; n < RANDOM_COUNT; n++) begin
            tc.value      = rx_data_t'($random(seed));
            tc.stop_level = 1'b1;
            tc.do_read    = 1'b1;
            tc.glitch_len = '0;
            tc.exp_data   = tc.value;                            // Well-formed and read each time
            tc.exp_status = '0;
            run_case(tc);
        end

        $display("Finished: %0d characters checked, %0d errors", chars_checked, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Run length follows from the number of characters
    initial begin
        int limit_ns;
        wait (cases_loaded);
        limit_ns = (cases.size() + RANDOM_COUNT) * BITS_PER_CASE * BIT_NS
                   + WATCHDOG_MARGIN * BIT_NS;
        #(limit_ns);
        $display("Watchdog expired at %0t, the run did not finish in time", $time);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/uart_rx_cases.txt ====
// Columns, all hex: byte stop_level read glitch_cycles exp_data exp_frame_error exp_overrun
// read 1 pulses i_read after the character; glitch is a low pulse sent before it

// Well-formed characters, bit order
55 1 1 00 55 0 0
A5 1 1 00 A5 0 0
01 1 1 00 01 0 0
80 1 1 00 80 0 0
00 1 1 00 00 0 0
FF 1 1 00 FF 0 0

// Bad stop bit, then cleared by a good one
3C 0 1 00 3C 1 0
C3 1 1 00 C3 0 0
7E 0 0 00 7E 1 0
81 1 1 00 81 0 1

// Overrun
12 1 0 00 12 0 0
34 1 1 00 34 0 1
11 1 0 00 11 0 0
22 1 0 00 22 0 1
33 1 1 00 33 0 1

// Start glitches shorter than half a bit
96 1 1 03 96 0 0
69 1 1 14 69 0 0
5A 1 1 32 5A 0 0
F0 1 1 3C F0 0 0
0F 1 1 00 0F 0 0

// Mixed
AA 0 1 00 AA 1 0
00 0 1 00 00 1 0
C0 1 1 00 C0 0 0
03 1 1 00 03 0 0
5B 1 0 00 5B 0 0
6D 0 1 00 6D 1 1
E7 1 1 00 E7 0 0
18 1 1 0A 18 0 0
24 1 1 00 24 0 0
FE 1 1 00 FE 0 0

// ==== src.f ====
hdl/uart_rx_pkg.sv
hdl/rx_sample_timer.sv
hdl/rx_control_fsm.sv
hdl/rx_shift_datapath.sv
hdl/rx_holding_buffer.sv
hdl/uart_rx_top.sv
testbench/tb_uart_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART receiver testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -j 0 \
    -f src.f \
    --top-module tb_uart_rx \
    -o tb_uart_rx

./obj_dir/tb_uart_rx > "$LOG"
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
